// File: hdl/udp_reply_settings.svh
`ifndef UDP_REPLY_SETTINGS_SVH
`define UDP_REPLY_SETTINGS_SVH

// listening port
// headers sent here get a reply, everything else is drained
`define LISTEN_PORT 16'h1234

// reply payload length in bytes
`define MSG_BYTES 12

// reply text, packed msb first
// byte 0 sits in bits [95:88] and goes out first
// "Uhello world" with a leading 0x55 marker byte
`define MSG_TEXT 96'h55_68_65_6C_6C_6F_20_77_6F_72_6C_64

// the stack fills in the reply source port
// from LISTEN_PORT on its side, same for ttl,
// dscp, checksum and length

`endif

// File: hdl/udp_reply_pkg.sv
package udp_reply_pkg;

    // stream and header field types
    typedef logic [7:0]  byte_t;      // one payload byte
    typedef logic [15:0] udp_port_t;  // udp port number
    typedef logic [31:0] ip_addr_t;   // ipv4 address

    // position inside the reply message
    // 4 bits covers up to 16 bytes
    typedef logic [3:0]  msg_index_t;

    // reply sequencing in reply_builder
    typedef enum logic [1:0] {
        REPLY_IDLE,     // waiting for a request
        REPLY_HEADER,   // header offered to the stack
        REPLY_PAYLOAD   // message bytes streaming out
    } reply_state_t;

    // REPLY_HEADER holds until tx_hdr_ready
    // REPLY_PAYLOAD ends on the tlast transfer

endpackage

// File: hdl/port_filter.sv
`timescale 1ns/1ps
`include "udp_reply_settings.svh"

// receive side of the core
// drains every udp header from the stack, keeps the sender of
// matching ones in a single request slot for the reply builder
module port_filter (
    input  logic                     clk,
    input  logic                     rst,
    // header from the udp stack
    input  logic                     rx_hdr_valid,
    input  udp_reply_pkg::udp_port_t rx_dest_port,
    input  udp_reply_pkg::ip_addr_t  rx_source_ip,
    input  udp_reply_pkg::udp_port_t rx_source_port,
    output logic                     rx_hdr_ready,
    // request to the reply builder
    input  logic                     req_take,
    output logic                     req_valid,
    output udp_reply_pkg::ip_addr_t  req_ip,
    output udp_reply_pkg::udp_port_t req_port
);

    logic match;     // header is for the listening port
    logic hdr_fire;  // header handshake this cycle
    logic accept;    // matching header taken

    assign match = (rx_dest_port == `LISTEN_PORT);

    // non-matching headers always go through
    // matching ones wait while the slot is full
    assign rx_hdr_ready = !match || !req_valid;

    assign hdr_fire = rx_hdr_valid && rx_hdr_ready;
    assign accept   = hdr_fire && match;

    // one-deep request slot
    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
        end else if (accept) begin
            req_valid <= 1'b1;  // only possible with slot empty
        end else if (req_take) begin
            req_valid <= 1'b0;  // builder copied it
        end
    end

    // requester address for the reply
    always_ff @(posedge clk) begin
        if (accept) begin
            req_ip   <= rx_source_ip;
            req_port <= rx_source_port;
        end
    end

    // builder may only take a request that is there
    take_needs_valid: assert property (
        @(posedge clk) disable iff (rst)
        req_take |-> req_valid
    ) else $error("port_filter: req_take with no pending request");

endmodule

// File: hdl/message_source.sv
`timescale 1ns/1ps
`include "udp_reply_settings.svh"

// endless byte stream of the reply message
// wraps after the last byte so every reply starts at byte 0
module message_source (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 msg_ready,
    output udp_reply_pkg::byte_t msg_data,
    output logic                 msg_valid,
    output logic                 msg_last
);

    localparam logic [`MSG_BYTES*8-1:0] MSG_TEXT = `MSG_TEXT;
    localparam udp_reply_pkg::msg_index_t LAST_IDX =
        udp_reply_pkg::msg_index_t'(`MSG_BYTES - 1);

    udp_reply_pkg::msg_index_t idx;       // byte on msg_data now
    udp_reply_pkg::msg_index_t idx_next;  // byte after this edge
    udp_reply_pkg::msg_index_t load_idx;  // byte to register

    // msb of the text goes first
    function automatic udp_reply_pkg::byte_t text_byte(input udp_reply_pkg::msg_index_t i);
        int sel;
        sel = `MSG_BYTES - 1 - int'(i);
        return MSG_TEXT[sel*8 +: 8];
    endfunction

    always_comb begin
        idx_next = idx;
        if (msg_valid && msg_ready) begin
            idx_next = (idx == LAST_IDX) ? '0 : idx + 1'b1;  // wrap
        end
    end

    assign load_idx = rst ? '0 : idx_next;  // byte 0 ready out of reset

    always_ff @(posedge clk) begin
        if (rst) begin
            idx       <= '0;
            msg_valid <= 1'b0;
            msg_last  <= 1'b0;
        end else begin
            idx       <= idx_next;
            msg_valid <= 1'b1;                  // always something to send
            msg_last  <= (idx_next == LAST_IDX);
        end
    end

    // registered data, held while not taken
    always_ff @(posedge clk) begin
        msg_data <= text_byte(load_idx);
    end

    last_on_final_byte: assert property (
        @(posedge clk) disable iff (rst)
        msg_last |-> (idx == LAST_IDX)
    ) else $error("message_source: msg_last away from final byte");

endmodule

// File: hdl/reply_builder.sv
`timescale 1ns/1ps

// reply sequencer
// takes one request, offers its header to the stack, then streams
// the message as the payload; first byte of each reply goes to leds
module reply_builder (
    input  logic                     clk,
    input  logic                     rst,
    // request from port_filter
    input  logic                     req_valid,
    input  udp_reply_pkg::ip_addr_t  req_ip,
    input  udp_reply_pkg::udp_port_t req_port,
    output logic                     req_take,
    // message stream
    input  udp_reply_pkg::byte_t     msg_data,
    input  logic                     msg_valid,
    input  logic                     msg_last,
    output logic                     msg_ready,
    // reply header to the stack
    output logic                     tx_hdr_valid,
    input  logic                     tx_hdr_ready,
    output udp_reply_pkg::ip_addr_t  tx_dest_ip,
    output udp_reply_pkg::udp_port_t tx_dest_port,
    // reply payload to the stack
    output udp_reply_pkg::byte_t     tx_tdata,
    output logic                     tx_tvalid,
    input  logic                     tx_tready,
    output logic                     tx_tlast,
    output udp_reply_pkg::byte_t     led
);

    udp_reply_pkg::reply_state_t state;
    udp_reply_pkg::reply_state_t state_next;

    logic in_payload;     // payload phase
    logic byte_fire;      // payload byte handshake
    logic first_pending;  // next byte is the first of this reply

    assign in_payload = (state == udp_reply_pkg::REPLY_PAYLOAD);

    // copy the request while idle
    assign req_take = (state == udp_reply_pkg::REPLY_IDLE) && req_valid;

    assign tx_hdr_valid = (state == udp_reply_pkg::REPLY_HEADER);

    // message passes straight through, only in payload phase
    assign tx_tdata  = msg_data;
    assign tx_tvalid = in_payload && msg_valid;
    assign tx_tlast  = in_payload && msg_last;
    assign msg_ready = in_payload && tx_tready;  // source stalls otherwise
    assign byte_fire = tx_tvalid && tx_tready;

    always_comb begin
        state_next = state;
        case (state)
            udp_reply_pkg::REPLY_IDLE: begin
                if (req_valid) begin
                    state_next = udp_reply_pkg::REPLY_HEADER;
                end
            end
            udp_reply_pkg::REPLY_HEADER: begin
                if (tx_hdr_ready) begin
                    state_next = udp_reply_pkg::REPLY_PAYLOAD;  // header accepted
                end
            end
            udp_reply_pkg::REPLY_PAYLOAD: begin
                if (byte_fire && tx_tlast) begin
                    state_next = udp_reply_pkg::REPLY_IDLE;  // end of reply
                end
            end
            default: state_next = udp_reply_pkg::REPLY_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= udp_reply_pkg::REPLY_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // header fields, stable for the whole reply
    always_ff @(posedge clk) begin
        if (req_take) begin
            tx_dest_ip   <= req_ip;
            tx_dest_port <= req_port;
        end
    end

    // led capture of the first transferred byte
    always_ff @(posedge clk) begin
        if (rst) begin
            first_pending <= 1'b0;
            led           <= '0;
        end else begin
            if (tx_hdr_valid && tx_hdr_ready) begin
                first_pending <= 1'b1;  // arm for this reply
            end else if (byte_fire && first_pending) begin
                first_pending <= 1'b0;
                led           <= tx_tdata;
            end
        end
    end

    // stack sees a steady header until it takes it
    hdr_held: assert property (
        @(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=>
            tx_hdr_valid && $stable(tx_dest_ip) && $stable(tx_dest_port)
    ) else $error("reply_builder: header changed before handshake");

endmodule

// File: hdl/udp_reply_core.sv
`timescale 1ns/1ps

// udp reply application core
// sits on the udp stack: filters headers by port and answers each
// match with the fixed message sent back to the requester
module udp_reply_core (
    input  logic                     clk,
    input  logic                     rst,
    // received udp header
    input  logic                     rx_hdr_valid,
    input  udp_reply_pkg::udp_port_t rx_dest_port,
    input  udp_reply_pkg::ip_addr_t  rx_source_ip,
    input  udp_reply_pkg::udp_port_t rx_source_port,
    output logic                     rx_hdr_ready,
    // reply header
    output logic                     tx_hdr_valid,
    input  logic                     tx_hdr_ready,
    output udp_reply_pkg::ip_addr_t  tx_dest_ip,
    output udp_reply_pkg::udp_port_t tx_dest_port,
    // reply payload
    output udp_reply_pkg::byte_t     tx_tdata,
    output logic                     tx_tvalid,
    input  logic                     tx_tready,
    output logic                     tx_tlast,
    output udp_reply_pkg::byte_t     led
);

    // filter to builder
    logic                     req_valid;
    logic                     req_take;
    udp_reply_pkg::ip_addr_t  req_ip;
    udp_reply_pkg::udp_port_t req_port;

    // source to builder
    udp_reply_pkg::byte_t     msg_data;
    logic                     msg_valid;
    logic                     msg_last;
    logic                     msg_ready;

    port_filter u_port_filter (
        .clk            (clk),
        .rst            (rst),
        .rx_hdr_valid   (rx_hdr_valid),
        .rx_dest_port   (rx_dest_port),
        .rx_source_ip   (rx_source_ip),
        .rx_source_port (rx_source_port),
        .rx_hdr_ready   (rx_hdr_ready),
        .req_take       (req_take),
        .req_valid      (req_valid),
        .req_ip         (req_ip),
        .req_port       (req_port)
    );

    message_source u_message_source (
        .clk       (clk),
        .rst       (rst),
        .msg_ready (msg_ready),
        .msg_data  (msg_data),
        .msg_valid (msg_valid),
        .msg_last  (msg_last)
    );

    reply_builder u_reply_builder (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_ip       (req_ip),
        .req_port     (req_port),
        .req_take     (req_take),
        .msg_data     (msg_data),
        .msg_valid    (msg_valid),
        .msg_last     (msg_last),
        .msg_ready    (msg_ready),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_hdr_ready (tx_hdr_ready),
        .tx_dest_ip   (tx_dest_ip),
        .tx_dest_port (tx_dest_port),
        .tx_tdata     (tx_tdata),
        .tx_tvalid    (tx_tvalid),
        .tx_tready    (tx_tready),
        .tx_tlast     (tx_tlast),
        .led          (led)
    );

endmodule

// File: tb/reply_checker.sv
`timescale 1ns/1ps
`include "udp_reply_settings.svh"

// watches the core ports and compares each reply with a model queue
module reply_checker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rx_hdr_valid,
    input  udp_reply_pkg::udp_port_t rx_dest_port,
    input  udp_reply_pkg::ip_addr_t  rx_source_ip,
    input  udp_reply_pkg::udp_port_t rx_source_port,
    input  logic                     rx_hdr_ready,
    input  logic                     tx_hdr_valid,
    input  logic                     tx_hdr_ready,
    input  udp_reply_pkg::ip_addr_t  tx_dest_ip,
    input  udp_reply_pkg::udp_port_t tx_dest_port,
    input  udp_reply_pkg::byte_t     tx_tdata,
    input  logic                     tx_tvalid,
    input  logic                     tx_tready,
    input  logic                     tx_tlast,
    input  udp_reply_pkg::byte_t     led,
    output int                       error_count,
    output int                       match_count,
    output int                       reply_count,
    output int                       pending,     // replies still owed
    output logic                     busy         // model is inside a reply
);

    logic [47:0]          expect_q[$];  // {ip, port} per matching header
    logic [47:0]          want;
    int                   byte_idx;     // next payload byte expected
    udp_reply_pkg::byte_t led_expect;
    logic                 was_rst;
    logic                 hdr_stall;    // header offered but not taken
    logic                 data_stall;   // byte offered but not taken
    logic [47:0]          hdr_prev;
    logic [8:0]           data_prev;    // {tlast, tdata}

    // message byte i, most significant first
    function automatic udp_reply_pkg::byte_t msg_byte(input int i);
        logic [`MSG_BYTES*8-1:0] text;
        text = `MSG_TEXT;
        return text[8*(`MSG_BYTES-1-i) +: 8];
    endfunction

    task automatic flag_error(input string msg);
        error_count++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    initial begin
        error_count = 0;
        match_count = 0;
        reply_count = 0;
        pending     = 0;
        busy        = 1'b0;
        led_expect  = '0;
        was_rst     = 1'b0;
        hdr_stall   = 1'b0;
        data_stall  = 1'b0;
    end

    always @(posedge clk) begin
        if (rst) begin
            was_rst    = 1'b1;
            hdr_stall  = 1'b0;
            data_stall = 1'b0;
        end else begin
            if (was_rst && (tx_hdr_valid || tx_tvalid))
                flag_error("tx valid high right after reset");
            was_rst = 1'b0;
            if (led !== led_expect)
                flag_error($sformatf("led %h, expected %h", led, led_expect));
            // receive side
            if (rx_hdr_valid && rx_dest_port != `LISTEN_PORT && !rx_hdr_ready)
                flag_error("non-matching header refused");
            if (rx_hdr_valid && rx_hdr_ready && rx_dest_port == `LISTEN_PORT) begin
                expect_q.push_back({rx_source_ip, rx_source_port});
                match_count++;
            end
            // stalled handshakes must hold
            if (hdr_stall && (!tx_hdr_valid || {tx_dest_ip, tx_dest_port} != hdr_prev))
                flag_error("reply header changed while stalled");
            if (data_stall && (!tx_tvalid || {tx_tlast, tx_tdata} != data_prev))
                flag_error("payload changed while stalled");
            // payload bytes
            if (tx_tvalid && !busy)
                flag_error("payload valid outside a reply");
            if (tx_tvalid && tx_tready && busy) begin
                if (tx_tdata !== msg_byte(byte_idx))
                    flag_error($sformatf("byte %0d is %h, expected %h",
                        byte_idx, tx_tdata, msg_byte(byte_idx)));
                if (tx_tlast !== (byte_idx == `MSG_BYTES - 1))
                    flag_error($sformatf("tlast %b on byte %0d", tx_tlast, byte_idx));
                if (byte_idx == 0)
                    led_expect = msg_byte(0);  // led shows it from next cycle
                byte_idx++;
                if (byte_idx == `MSG_BYTES)
                    busy = 1'b0;
            end
            // header handshake opens a reply
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (busy)
                    flag_error("reply header during a reply");
                if (expect_q.size() == 0) begin
                    flag_error("reply with no matching header");
                end else begin
                    want = expect_q.pop_front();
                    if ({tx_dest_ip, tx_dest_port} !== want)
                        flag_error($sformatf("reply to %h:%h, expected %h:%h",
                            tx_dest_ip, tx_dest_port, want[47:16], want[15:0]));
                end
                reply_count++;
                busy     = 1'b1;
                byte_idx = 0;
            end
            hdr_stall  = tx_hdr_valid && !tx_hdr_ready;
            hdr_prev   = {tx_dest_ip, tx_dest_port};
            data_stall = tx_tvalid && !tx_tready;
            data_prev  = {tx_tlast, tx_tdata};
            pending    = expect_q.size();
        end
    end

endmodule

// File: tb/tb_udp_reply_core.sv
`timescale 1ns/1ps
`include "udp_reply_settings.svh"

module tb_udp_reply_core;

    localparam int NUM_HDRS       = 200;
    localparam int TIMEOUT_CYCLES = NUM_HDRS * 60;

    logic                     clk;
    logic                     rst;
    logic                     rx_hdr_valid;
    udp_reply_pkg::udp_port_t rx_dest_port;
    udp_reply_pkg::ip_addr_t  rx_source_ip;
    udp_reply_pkg::udp_port_t rx_source_port;
    logic                     rx_hdr_ready;
    logic                     tx_hdr_valid;
    logic                     tx_hdr_ready;
    udp_reply_pkg::ip_addr_t  tx_dest_ip;
    udp_reply_pkg::udp_port_t tx_dest_port;
    udp_reply_pkg::byte_t     tx_tdata;
    logic                     tx_tvalid;
    logic                     tx_tready;
    logic                     tx_tlast;
    udp_reply_pkg::byte_t     led;
    int                       error_count;
    int                       match_count;
    int                       reply_count;
    int                       pending;
    logic                     busy;
    int                       cycles;
    int                       n;

    udp_reply_core UUT (.*);

    reply_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    task automatic print_counts();
        $display("errors %0d, matching headers %0d, replies %0d, still queued %0d",
            error_count, match_count, reply_count, pending);
    endtask

    // one header from the stack, random gap first
    task automatic send_header();
        int                       gap;
        logic                     accepted;
        udp_reply_pkg::udp_port_t port;
        gap  = $urandom % 4;
        port = 16'($urandom);
        if (port == `LISTEN_PORT)
            port = ~port;                  // keep it a non-match
        if ($urandom % 2)
            port = `LISTEN_PORT;           // half the headers match
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        rx_dest_port   = port;
        rx_source_ip   = $urandom;
        rx_source_port = 16'($urandom);
        rx_hdr_valid   = 1'b1;
        do begin
            @(negedge clk);
            accepted = rx_hdr_ready;       // same as at the coming edge
            @(posedge clk);
            #1;
        end while (!accepted);
        rx_hdr_valid = 1'b0;
    endtask

    // random back-pressure from the stack, 70% ready
    initial begin
        forever begin
            @(posedge clk);
            #1;
            tx_hdr_ready = ($urandom % 10) < 7;
            tx_tready    = ($urandom % 10) < 7;
        end
    end

    initial begin
        void'($urandom(2077));
        rst            = 1'b1;
        rx_hdr_valid   = 1'b0;
        rx_dest_port   = '0;
        rx_source_ip   = '0;
        rx_source_port = '0;
        tx_hdr_ready   = 1'b0;
        tx_tready      = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        for (n = 0; n < NUM_HDRS; n++) begin
            send_header();
        end
        while (pending != 0 || busy) @(negedge clk);  // drain replies
        repeat (20) @(negedge clk);                   // nothing extra may follow
        print_counts();
        if (error_count == 0 && reply_count == match_count && pending == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // run limit
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: replies did not finish");
        print_counts();
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: compile.f
+incdir+hdl
hdl/udp_reply_pkg.sv
hdl/port_filter.sv
hdl/message_source.sv
hdl/reply_builder.sv
hdl/udp_reply_core.sv
tb/reply_checker.sv
tb/tb_udp_reply_core.sv
